// ==== cdi_host_pkg.sv ====
package cdi_host_pkg;

    // ========================================================================
    // Bus widths
    // ========================================================================
    localparam int sdram_addr_w = 25;
    localparam int sd_word_w    = 16;
    localparam int nvram_adr_w  = 13;
    localparam int worm_adr_w   = 13;
    localparam int status_w     = 128;

    // Menu status bit positions
    localparam int stat_reset_bit         = 0;
    localparam int stat_nvram_noreset_bit = 8;
    localparam int stat_ar_lo             = 121;
    localparam int stat_ar_hi             = 122;

    // Boot ROM images live above this prefix in SDRAM
    localparam logic [2:0] rom_region_prefix = 3'b001;

    // Download index bit that selects the slave ROM
    localparam int slave_index_bit = 6;

    // ========================================================================
    // Enumerations and shared types
    // ========================================================================
    typedef enum logic [1:0] {
        rom_download,
        refresh,
        idle
    } sdram_owner_e;

    typedef enum logic [3:0] {
        nvram_idle,
        nvram_wait_for_ack,
        nvram_backup0,
        nvram_backup1,
        nvram_backup2,
        nvram_backup3,
        nvram_restore0,
        nvram_restore1,
        nvram_restore2
    } nvram_state_e;

    // One SD word, seen either whole or as two bytes
    typedef union packed {
        logic [sd_word_w-1:0] full;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
    } sd_word_u;

endpackage

// ==== host_reset_ctrl.sv ====
`timescale 1ns/1ps

module host_reset_ctrl
    import cdi_host_pkg::*;
(
    input  logic                clk_sys,
    input  logic                cditop_reset,
    input  logic [status_w-1:0] status,
    input  logic [1:0]          buttons,
    input  logic                ioctl_download,
    input  logic                nvram_media_change,
    input  logic [63:0]         img_size,
    output logic                core_reset,
    output logic                nvram_img_mount,
    output logic                nvram_img_mounted,
    output logic [12:0]         video_arx,
    output logic [12:0]         video_ary
);

    logic [1:0] ar;
    logic       reset_on_mount;

    // Aspect ratio menu entry, 0 keeps the original 4:3
    assign ar        = status[stat_ar_hi:stat_ar_lo];
    assign video_arx = (ar == 2'd0) ? 13'd4 : (13'(ar) - 13'd1);
    assign video_ary = (ar == 2'd0) ? 13'd3 : 13'd0;

    // A freshly inserted image with real content
    assign nvram_img_mount = nvram_media_change && (img_size != 64'd0);
    assign reset_on_mount  = nvram_img_mount && !status[stat_nvram_noreset_bit];

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            nvram_img_mounted <= 1'b0;
        end else if (nvram_media_change) begin
            nvram_img_mounted <= (img_size != 64'd0);
        end
    end

    // All reset sources merged into one registered core reset
    always_ff @(posedge clk_sys) begin
        core_reset <= cditop_reset || status[stat_reset_bit] || buttons[1] ||
                      ioctl_download || reset_on_mount;
    end

endmodule

// ==== worm_byte_splitter.sv ====
`timescale 1ns/1ps

module worm_byte_splitter
    import cdi_host_pkg::*;
(
    input  logic                    clk_sys,
    input  logic                    cditop_reset,
    input  logic                    ioctl_wr,
    input  logic [15:0]             ioctl_index,
    input  logic [sdram_addr_w-1:0] ioctl_addr,
    input  logic [sd_word_w-1:0]    ioctl_dout,
    output logic [worm_adr_w-1:0]   worm_adr,
    output logic [7:0]              worm_data,
    output logic                    worm_wr
);

    logic       slave_wr;
    logic       slave_wr_q;
    logic [7:0] second_byte;

    assign slave_wr = ioctl_wr && ioctl_index[slave_index_bit];

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            slave_wr_q <= 1'b0;
            worm_wr    <= 1'b0;
        end else begin
            slave_wr_q <= slave_wr;
            worm_wr    <= slave_wr || slave_wr_q;
        end
    end

    // Low byte goes out first, the high byte waits one cycle
    always_ff @(posedge clk_sys) begin
        if (slave_wr) begin
            worm_adr    <= ioctl_addr[worm_adr_w-1:0];
            worm_data   <= ioctl_dout[7:0];
            second_byte <= ioctl_dout[15:8];
        end else begin
            worm_adr[0] <= 1'b1;
            worm_data   <= second_byte;
        end
    end

endmodule

// ==== sdram_prepare_arbiter.sv ====
`timescale 1ns/1ps

module sdram_prepare_arbiter
    import cdi_host_pkg::*;
(
    input  logic                    clk_sys,
    input  logic                    cditop_reset,
    input  logic                    core_reset,
    input  logic                    ioctl_wr,
    input  logic [15:0]             ioctl_index,
    input  logic [sdram_addr_w-1:0] ioctl_addr,
    input  logic [sd_word_w-1:0]    ioctl_dout,
    input  logic                    ioctl_download,
    input  logic [sdram_addr_w-1:0] core_sdram_addr,
    input  logic [sd_word_w-1:0]    core_sdram_din,
    input  logic                    core_sdram_rd,
    input  logic                    core_sdram_wr,
    input  logic                    core_sdram_word,
    input  logic                    core_sdram_refresh,
    input  logic                    core_sdram_burst,
    input  logic                    sdram_busy,
    output logic [sdram_addr_w-1:0] sdram_addr,
    output logic [sd_word_w-1:0]    sdram_din,
    output logic                    sdram_rd,
    output logic                    sdram_wr,
    output logic                    sdram_word,
    output logic                    sdram_refresh,
    output logic                    sdram_burst,
    output logic                    ioctl_overflow
);

    sdram_owner_e owner;
    sdram_owner_e owner_q;
    sdram_owner_e owner_next;

    logic                    wr_latch;
    logic                    busy_q;
    logic                    download_q;
    logic                    main_rom_wr;
    logic                    busy_fall;
    sd_word_u                swapped;
    logic [sdram_addr_w-1:0] prep_addr;
    logic                    prep_rd;
    logic                    prep_wr;
    logic                    prep_refresh;

    assign main_rom_wr = ioctl_wr && !ioctl_index[slave_index_bit];
    assign busy_fall   = busy_q && !sdram_busy;

    // ========================================================================
    // Owner selection, frozen while the SDRAM is busy
    // ========================================================================
    always_comb begin
        owner_next = idle;
        if (core_reset) begin
            owner_next = wr_latch ? rom_download : refresh;
        end
        owner = sdram_busy ? owner_q : owner_next;
    end

    always_ff @(posedge clk_sys) begin
        busy_q     <= sdram_busy;
        download_q <= ioctl_download;
        if (cditop_reset) begin
            owner_q        <= idle;
            wr_latch       <= 1'b0;
            ioctl_overflow <= 1'b0;
        end else begin
            // A new download starts from a clean owner
            owner_q <= (ioctl_download && !download_q) ? idle : owner;
            if (wr_latch && ioctl_wr) begin
                ioctl_overflow <= 1'b1;
            end
            if (main_rom_wr) begin
                wr_latch <= 1'b1;
            end else if (owner_q == rom_download && busy_fall) begin
                wr_latch <= 1'b0;
            end
        end
    end

    // ========================================================================
    // Request of the chosen owner
    // ========================================================================
    // SDRAM expects big endian words
    assign swapped.bytes.hi = ioctl_dout[7:0];
    assign swapped.bytes.lo = ioctl_dout[15:8];
    assign prep_addr        = {rom_region_prefix, ioctl_addr[21:1], 1'b0};

    always_comb begin
        prep_rd      = 1'b0;
        prep_wr      = 1'b0;
        prep_refresh = 1'b0;
        case (owner)
            rom_download: prep_wr = 1'b1;
            refresh: begin
                prep_rd      = 1'b1;
                prep_refresh = 1'b1;
            end
            default: ;
        endcase
        if (sdram_busy) begin
            prep_rd = 1'b0;
            prep_wr = 1'b0;
        end
    end

    // Core owns the port outside of reset
    assign sdram_addr    = core_reset ? prep_addr    : core_sdram_addr;
    assign sdram_din     = core_reset ? swapped.full : core_sdram_din;
    assign sdram_rd      = core_reset ? prep_rd      : core_sdram_rd;
    assign sdram_wr      = core_reset ? prep_wr      : core_sdram_wr;
    assign sdram_word    = core_reset ? 1'b1         : core_sdram_word;
    assign sdram_refresh = core_reset ? prep_refresh : core_sdram_refresh;
    assign sdram_burst   = core_reset ? 1'b0         : core_sdram_burst;

endmodule

// ==== nvram_transfer_fsm.sv ====
`timescale 1ns/1ps

module nvram_transfer_fsm
    import cdi_host_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   cditop_reset,
    input  logic                   core_reset,
    input  logic                   nvram_img_mount,
    input  logic                   nvram_img_mounted,
    input  logic                   osd_status,
    input  logic                   nvram_hps_ack,
    input  logic [7:0]             sd_buff_addr,
    input  logic                   sd_buff_wr,
    input  logic [sd_word_w-1:0]   sd_buff_dout,
    input  logic [7:0]             nvram_backup_data,
    input  logic                   nvram_cpu_changed,
    output logic                   nvram_hps_rd,
    output logic                   nvram_hps_wr,
    output logic [sd_word_w-1:0]   nvram_hps_din,
    output logic [nvram_adr_w-1:0] nvram_adr,
    output logic [7:0]             nvram_restore_data,
    output logic                   nvram_restore_write,
    output logic                   nvram_allow_cpu_access,
    output logic                   led_user
);

    nvram_state_e state;

    sd_word_u restore_word;
    sd_word_u backup_word;
    logic     backup_pending;
    logic     osd_status_q;
    logic     buff_addr0_q;

    // User LED shows unsaved NvRAM content
    assign led_user      = backup_pending;
    assign nvram_hps_din = backup_word.full;

    // Even addresses take the low byte
    assign nvram_restore_data = nvram_adr[0] ? restore_word.bytes.hi : restore_word.bytes.lo;

    always_ff @(posedge clk_sys) begin
        osd_status_q <= osd_status;
        buff_addr0_q <= sd_buff_addr[0];

        if (core_reset) begin
            backup_pending <= 1'b0;
        end else if (nvram_cpu_changed && nvram_img_mounted) begin
            backup_pending <= 1'b1;
        end

        if (cditop_reset) begin
            state                  <= nvram_idle;
            nvram_hps_rd           <= 1'b0;
            nvram_hps_wr           <= 1'b0;
            nvram_restore_write    <= 1'b0;
            nvram_allow_cpu_access <= 1'b1;
        end else begin
            nvram_restore_write <= 1'b0;

            // Host took the request
            if (nvram_hps_ack) begin
                nvram_hps_rd <= 1'b0;
                nvram_hps_wr <= 1'b0;
            end

            case (state)
                nvram_idle: begin
                    nvram_allow_cpu_access <= 1'b1;
                    nvram_adr              <= '0;
                    if (nvram_img_mount) begin
                        nvram_hps_rd           <= 1'b1;
                        nvram_allow_cpu_access <= 1'b0;
                        state                  <= nvram_wait_for_ack;
                    end else if (backup_pending && osd_status && !osd_status_q) begin
                        // OSD just opened with changed content
                        backup_pending         <= 1'b0;
                        nvram_hps_wr           <= 1'b1;
                        nvram_allow_cpu_access <= 1'b0;
                        state                  <= nvram_wait_for_ack;
                    end
                end
                nvram_wait_for_ack: begin
                    if (nvram_hps_ack && nvram_hps_rd) begin
                        state <= nvram_restore0;
                    end
                    if (nvram_hps_ack && nvram_hps_wr) begin
                        state <= nvram_backup0;
                    end
                end

                // ============================================================
                // Backup, two registered reads per SD word
                // ============================================================
                nvram_backup0: begin
                    nvram_adr <= nvram_adr + 1'b1;
                    state     <= nvram_backup1;
                end
                nvram_backup1: begin
                    backup_word.bytes.lo <= nvram_backup_data;
                    nvram_adr            <= nvram_adr + 1'b1;
                    state                <= nvram_backup2;
                end
                nvram_backup2: begin
                    backup_word.bytes.hi <= nvram_backup_data;
                    state                <= nvram_backup3;
                end
                nvram_backup3: begin
                    // Host moved on to the next word
                    if (buff_addr0_q != sd_buff_addr[0]) begin
                        nvram_adr <= nvram_adr + 1'b1;
                        state     <= nvram_backup1;
                    end
                    if (!nvram_hps_ack) begin
                        state <= nvram_idle;
                    end
                end

                // ============================================================
                // Restore, one SD word becomes two byte writes
                // ============================================================
                nvram_restore0: begin
                    if (sd_buff_wr) begin
                        restore_word.full   <= sd_buff_dout;
                        nvram_restore_write <= 1'b1;
                        state               <= nvram_restore1;
                    end
                    if (!nvram_hps_ack) begin
                        nvram_allow_cpu_access <= 1'b1;
                        state                  <= nvram_idle;
                    end
                end
                nvram_restore1: begin
                    nvram_restore_write <= 1'b1;
                    nvram_adr           <= nvram_adr + 1'b1;
                    state               <= nvram_restore2;
                end
                nvram_restore2: begin
                    nvram_adr <= nvram_adr + 1'b1;
                    state     <= nvram_restore0;
                end
                default: state <= nvram_idle;
            endcase
        end
    end

endmodule

// ==== cdi_host_bridge.sv ====
`timescale 1ns/1ps

module cdi_host_bridge
    import cdi_host_pkg::*;
(
    input  logic                    clk_sys,
    input  logic                    cditop_reset,
    // Download
    input  logic                    ioctl_download,
    input  logic                    ioctl_wr,
    input  logic [15:0]             ioctl_index,
    input  logic [sdram_addr_w-1:0] ioctl_addr,
    input  logic [sd_word_w-1:0]    ioctl_dout,
    // Menu
    input  logic [status_w-1:0]     status,
    input  logic [1:0]              buttons,
    input  logic                    osd_status,
    // Core SDRAM request
    input  logic [sdram_addr_w-1:0] core_sdram_addr,
    input  logic [sd_word_w-1:0]    core_sdram_din,
    input  logic                    core_sdram_rd,
    input  logic                    core_sdram_wr,
    input  logic                    core_sdram_word,
    input  logic                    core_sdram_refresh,
    input  logic                    core_sdram_burst,
    // SDRAM port
    output logic [sdram_addr_w-1:0] sdram_addr,
    output logic [sd_word_w-1:0]    sdram_din,
    output logic                    sdram_rd,
    output logic                    sdram_wr,
    output logic                    sdram_word,
    output logic                    sdram_refresh,
    output logic                    sdram_burst,
    input  logic                    sdram_busy,
    // SD host slot
    output logic                    nvram_hps_rd,
    output logic                    nvram_hps_wr,
    input  logic                    nvram_hps_ack,
    input  logic [7:0]              sd_buff_addr,
    input  logic                    sd_buff_wr,
    input  logic [sd_word_w-1:0]    sd_buff_dout,
    output logic [sd_word_w-1:0]    nvram_hps_din,
    input  logic                    nvram_media_change,
    input  logic [63:0]             img_size,
    // NvRAM memory
    output logic [nvram_adr_w-1:0]  nvram_adr,
    output logic [7:0]              nvram_restore_data,
    output logic                    nvram_restore_write,
    input  logic [7:0]              nvram_backup_data,
    input  logic                    nvram_cpu_changed,
    output logic                    nvram_allow_cpu_access,
    // Slave memory
    output logic [worm_adr_w-1:0]   worm_adr,
    output logic [7:0]              worm_data,
    output logic                    worm_wr,
    // Misc
    output logic                    core_reset,
    output logic [12:0]             video_arx,
    output logic [12:0]             video_ary,
    output logic                    led_user,
    output logic                    ioctl_overflow
);

    logic nvram_img_mount;
    logic nvram_img_mounted;

    host_reset_ctrl i_reset_ctrl (
        .clk_sys, .cditop_reset, .status, .buttons, .ioctl_download,
        .nvram_media_change, .img_size, .core_reset, .nvram_img_mount,
        .nvram_img_mounted, .video_arx, .video_ary
    );

    worm_byte_splitter i_worm_splitter (
        .clk_sys, .cditop_reset, .ioctl_wr, .ioctl_index, .ioctl_addr,
        .ioctl_dout, .worm_adr, .worm_data, .worm_wr
    );

    sdram_prepare_arbiter i_sdram_arbiter (
        .clk_sys, .cditop_reset, .core_reset, .ioctl_wr, .ioctl_index,
        .ioctl_addr, .ioctl_dout, .ioctl_download, .core_sdram_addr,
        .core_sdram_din, .core_sdram_rd, .core_sdram_wr, .core_sdram_word,
        .core_sdram_refresh, .core_sdram_burst, .sdram_busy, .sdram_addr,
        .sdram_din, .sdram_rd, .sdram_wr, .sdram_word, .sdram_refresh,
        .sdram_burst, .ioctl_overflow
    );

    nvram_transfer_fsm i_nvram_fsm (
        .clk_sys, .cditop_reset, .core_reset, .nvram_img_mount,
        .nvram_img_mounted, .osd_status, .nvram_hps_ack, .sd_buff_addr,
        .sd_buff_wr, .sd_buff_dout, .nvram_backup_data, .nvram_cpu_changed,
        .nvram_hps_rd, .nvram_hps_wr, .nvram_hps_din, .nvram_adr,
        .nvram_restore_data, .nvram_restore_write, .nvram_allow_cpu_access,
        .led_user
    );

endmodule

// ==== tb_cdi_host_bridge.sv ====
`timescale 1ns/1ps

module tb_cdi_host_bridge;

    localparam int words           = 4096;
    localparam int watchdog_cycles = 2 * words * 6 + words * 5 + 4000;

    logic         clk_sys = 1'b0;
    logic         cditop_reset = 1'b1;
    logic         ioctl_download = 1'b0, ioctl_wr = 1'b0;
    logic [15:0]  ioctl_index = '0;
    logic [24:0]  ioctl_addr = '0;
    logic [15:0]  ioctl_dout = '0;
    logic [127:0] status = '0;
    logic [1:0]   buttons = '0;
    logic         osd_status = 1'b0;
    logic [24:0]  core_sdram_addr = '0;
    logic [15:0]  core_sdram_din = '0;
    logic         core_sdram_rd = 1'b0, core_sdram_wr = 1'b0, core_sdram_word = 1'b0;
    logic         core_sdram_refresh = 1'b0, core_sdram_burst = 1'b0;
    logic [24:0]  sdram_addr;
    logic [15:0]  sdram_din;
    logic         sdram_rd, sdram_wr, sdram_word, sdram_refresh, sdram_burst;
    logic         sdram_busy = 1'b0;
    logic         nvram_hps_rd, nvram_hps_wr;
    logic         nvram_hps_ack = 1'b0;
    logic [7:0]   sd_buff_addr = '0;
    logic         sd_buff_wr = 1'b0;
    logic [15:0]  sd_buff_dout = '0;
    logic [15:0]  nvram_hps_din;
    logic         nvram_media_change = 1'b0;
    logic [63:0]  img_size = '0;
    logic [12:0]  nvram_adr;
    logic [7:0]   nvram_restore_data;
    logic         nvram_restore_write;
    logic [7:0]   nvram_backup_data = '0;
    logic         nvram_cpu_changed = 1'b0;
    logic         nvram_allow_cpu_access;
    logic [12:0]  worm_adr;
    logic [7:0]   worm_data;
    logic         worm_wr, core_reset, led_user, ioctl_overflow;
    logic [12:0]  video_arx, video_ary;

    int           errors = 0;
    int           busy_cnt = 0;
    logic [7:0]   nvram_mem [0:2*words-1];
    logic [15:0]  image [0:words-1];
    logic [24:0]  wr_addr_q[$];
    logic [15:0]  wr_din_q[$];
    logic         wr_word_q[$];

    cdi_host_bridge i_dut (.*);

    always #4 clk_sys = ~clk_sys;

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("** Error %s: expected %0h, actual %0h", name, exp, act);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("** Error %s", what);
        errors++;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_sys);
    endtask

    // ========================================================================
    // Models of the SDRAM busy line and the NvRAM byte memory
    // ========================================================================
    always @(negedge clk_sys) begin
        if (core_reset === 1'b1 && sdram_busy && (sdram_rd || sdram_wr)) begin
            report_failure("SDRAM request shown while the SDRAM is busy");
        end
        if (busy_cnt != 0) begin
            busy_cnt = busy_cnt - 1;
            sdram_busy <= (busy_cnt != 0);
        end else if (sdram_rd === 1'b1 || sdram_wr === 1'b1) begin
            // Taken at the next rising edge, busy follows one cycle later
            busy_cnt = 3 + int'($urandom % 4);
            if (core_reset && sdram_wr) begin
                wr_addr_q.push_back(sdram_addr);
                wr_din_q.push_back(sdram_din);
                wr_word_q.push_back(sdram_word);
            end
        end
    end

    // Registered read, one cycle behind the address
    always @(posedge clk_sys) begin
        if (nvram_restore_write) begin
            nvram_mem[nvram_adr] <= nvram_restore_data;
        end
        nvram_backup_data <= nvram_mem[nvram_adr];
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_sys);
        $display("Watchdog expired before the tests finished");
        $display("errors: %0d", errors + 1);
        $display("TB FAILED");
        $finish;
    end

    // ========================================================================
    // NvRAM image transfers
    // ========================================================================
    task automatic run_restore(input logic noreset);
        int n;
        int bad;
        for (int k = 0; k < words; k++) begin
            image[k] = 16'($urandom);
        end
        @(negedge clk_sys);
        status[8] <= noreset;
        img_size <= 64'd8192;
        nvram_media_change <= 1'b1;
        @(negedge clk_sys);
        nvram_media_change <= 1'b0;
        if (core_reset !== !noreset) report_mismatch("mount_reset", !noreset, core_reset);
        n = 0;
        while (nvram_hps_rd !== 1'b1 && n < 20) begin
            @(negedge clk_sys);
            n++;
        end
        if (nvram_hps_rd !== 1'b1) report_failure("restore never requested the image");
        nvram_hps_ack <= 1'b1;
        @(negedge clk_sys);
        bad = 0;
        for (int k = 0; k < words; k++) begin
            sd_buff_addr <= 8'(k);
            sd_buff_dout <= image[k];
            sd_buff_wr <= 1'b1;
            @(negedge clk_sys);
            sd_buff_wr <= 1'b0;
            wait_cycles(3);
            if (nvram_allow_cpu_access !== 1'b0) begin
                if (bad == 0) report_failure("CPU access allowed during restore");
                else errors++;
                bad++;
            end
        end
        nvram_hps_ack <= 1'b0;
        n = 0;
        while (nvram_allow_cpu_access !== 1'b1 && n < 20) begin
            @(negedge clk_sys);
            n++;
        end
        if (nvram_allow_cpu_access !== 1'b1) report_failure("CPU access not returned");
        bad = 0;
        for (int k = 0; k < words; k++) begin
            if (nvram_mem[2*k] !== image[k][7:0] || nvram_mem[2*k+1] !== image[k][15:8]) begin
                if (bad < 4) begin
                    report_mismatch("restore_word", image[k],
                                    {nvram_mem[2*k+1], nvram_mem[2*k]});
                end else begin
                    errors++;
                end
                bad++;
            end
        end
    endtask

    task automatic run_backup();
        int n;
        int bad;
        logic [15:0] exp;
        for (int i = 0; i < 2 * words; i++) begin
            nvram_mem[i] = 8'($urandom);
        end
        @(negedge clk_sys);
        sd_buff_addr <= 8'd0;
        nvram_cpu_changed <= 1'b1;
        @(negedge clk_sys);
        nvram_cpu_changed <= 1'b0;
        if (led_user !== 1'b1) report_mismatch("led_set", 1, led_user);
        osd_status <= 1'b1;
        n = 0;
        @(negedge clk_sys);
        while (nvram_hps_wr !== 1'b1 && n < 20) begin
            @(negedge clk_sys);
            n++;
        end
        if (nvram_hps_wr !== 1'b1) report_failure("backup never requested a write");
        if (led_user !== 1'b0) report_mismatch("led_clear", 0, led_user);
        nvram_hps_ack <= 1'b1;
        bad = 0;
        for (int k = 0; k < words; k++) begin
            if (k == 0) begin
                wait_cycles(5);
            end else begin
                sd_buff_addr <= 8'(k);
                wait_cycles(4);
            end
            exp = {nvram_mem[2*k+1], nvram_mem[2*k]};
            if (nvram_hps_din !== exp) begin
                if (bad < 4) report_mismatch("backup_word", exp, nvram_hps_din);
                else errors++;
                bad++;
            end
        end
        nvram_hps_ack <= 1'b0;
        osd_status <= 1'b0;
        wait_cycles(4);
        if (nvram_allow_cpu_access !== 1'b1) report_failure("CPU access not returned");
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        int n;
        logic        exp_rst;
        logic [24:0] addr;
        logic [15:0] data;
        logic [45:0] exp_port;

        void'($urandom(32'h2f6e1fba));
        wait_cycles(10);
        cditop_reset <= 1'b0;
        wait_cycles(3);

        // Core reset sources
        for (int i = 0; i < 60; i++) begin
            status[0] <= ($urandom % 4) == 0;
            buttons <= {($urandom % 4) == 0, 1'b0};
            ioctl_download <= ($urandom % 4) == 0;
            @(negedge clk_sys);
            exp_rst = status[0] | buttons[1] | ioctl_download;
            if (core_reset !== exp_rst) report_mismatch("core_reset", exp_rst, core_reset);
        end
        status[0] <= 1'b0;
        buttons <= '0;
        ioctl_download <= 1'b0;
        for (int s = 0; s < 4; s++) begin
            status[122:121] <= 2'(s);
            @(negedge clk_sys);
            if (video_arx !== ((s == 0) ? 13'd4 : 13'(s - 1)))
                report_mismatch("video_arx", (s == 0) ? 4 : s - 1, video_arx);
            if (video_ary !== ((s == 0) ? 13'd3 : 13'd0))
                report_mismatch("video_ary", (s == 0) ? 3 : 0, video_ary);
        end

        // Empty image leaves the LED alone
        nvram_media_change <= 1'b1;
        img_size <= 64'd0;
        @(negedge clk_sys);
        nvram_media_change <= 1'b0;
        nvram_cpu_changed <= 1'b1;
        @(negedge clk_sys);
        nvram_cpu_changed <= 1'b0;
        @(negedge clk_sys);
        if (led_user !== 1'b0) report_mismatch("led_unmounted", 0, led_user);

        // Slave ROM byte split
        for (int i = 0; i < 30; i++) begin
            addr = 25'($urandom);
            data = 16'($urandom);
            ioctl_index <= 16'($urandom) | 16'h0040;
            ioctl_addr <= addr;
            ioctl_dout <= data;
            ioctl_wr <= 1'b1;
            @(negedge clk_sys);
            ioctl_wr <= 1'b0;
            if ({worm_wr, worm_adr, worm_data} !== {1'b1, addr[12:0], data[7:0]})
                report_mismatch("worm_first", {1'b1, addr[12:0], data[7:0]},
                                {worm_wr, worm_adr, worm_data});
            @(negedge clk_sys);
            if ({worm_wr, worm_adr, worm_data} !== {1'b1, addr[12:1], 1'b1, data[15:8]})
                report_mismatch("worm_second", {1'b1, addr[12:1], 1'b1, data[15:8]},
                                {worm_wr, worm_adr, worm_data});
            @(negedge clk_sys);
            if (worm_wr !== 1'b0) report_mismatch("worm_extra", 0, worm_wr);
        end

        // Boot ROM download while the core sits in reset
        ioctl_download <= 1'b1;
        wait_cycles(20);
        wr_addr_q.delete();
        wr_din_q.delete();
        wr_word_q.delete();
        for (int i = 0; i < 20; i++) begin
            addr = 25'($urandom);
            data = 16'($urandom);
            ioctl_index <= 16'($urandom) & 16'hffbf;
            ioctl_addr <= addr;
            ioctl_dout <= data;
            ioctl_wr <= 1'b1;
            @(negedge clk_sys);
            ioctl_wr <= 1'b0;
            n = 0;
            while (wr_addr_q.size() == 0 && n < 50) begin
                @(negedge clk_sys);
                n++;
            end
            if (wr_addr_q.size() == 0) begin
                report_failure("download word never reached the SDRAM");
            end else begin
                exp_port = {cdi_host_pkg::rom_region_prefix, addr[21:1], 1'b0,
                            data[7:0], data[15:8], 1'b1, 4'd0};
                if ({wr_addr_q[0], wr_din_q[0], wr_word_q[0], 4'd0} !== exp_port)
                    report_mismatch("rom_write", exp_port,
                                    {wr_addr_q[0], wr_din_q[0], wr_word_q[0], 4'd0});
                void'(wr_addr_q.pop_front());
                void'(wr_din_q.pop_front());
                void'(wr_word_q.pop_front());
            end
            // The latch clears when the busy period of the write ends
            n = 0;
            while (sdram_busy !== 1'b1 && n < 10) begin
                @(negedge clk_sys);
                n++;
            end
            while (sdram_busy === 1'b1 && n < 20) begin
                @(negedge clk_sys);
                n++;
            end
            wait_cycles(2);
            if (wr_addr_q.size() != 0) report_failure("download word written twice");
        end
        if (ioctl_overflow !== 1'b0) report_mismatch("overflow_early", 0, ioctl_overflow);
        ioctl_wr <= 1'b1;
        @(negedge clk_sys);
        @(negedge clk_sys);
        ioctl_wr <= 1'b0;
        @(negedge clk_sys);
        if (ioctl_overflow !== 1'b1) report_mismatch("overflow", 1, ioctl_overflow);
        wait_cycles(40);

        // Refresh owns the idle port during reset
        for (int i = 0; i < 80; i++) begin
            @(negedge clk_sys);
            if (!sdram_busy && {sdram_rd, sdram_wr, sdram_refresh} !== 3'b101)
                report_mismatch("refresh", 3'b101, {sdram_rd, sdram_wr, sdram_refresh});
        end

        // Core requests pass straight through
        ioctl_download <= 1'b0;
        wait_cycles(3);
        if (core_reset !== 1'b0) report_mismatch("core_reset_release", 0, core_reset);
        for (int i = 0; i < 100; i++) begin
            core_sdram_addr <= 25'($urandom);
            core_sdram_din <= 16'($urandom);
            {core_sdram_rd, core_sdram_wr, core_sdram_word} <= 3'($urandom);
            {core_sdram_refresh, core_sdram_burst} <= 2'($urandom);
            @(negedge clk_sys);
            exp_port = {core_sdram_addr, core_sdram_din, core_sdram_rd, core_sdram_wr,
                        core_sdram_word, core_sdram_refresh, core_sdram_burst};
            if ({sdram_addr, sdram_din, sdram_rd, sdram_wr, sdram_word, sdram_refresh,
                 sdram_burst} !== exp_port)
                report_mismatch("pass_through", exp_port, {sdram_addr, sdram_din, sdram_rd,
                                sdram_wr, sdram_word, sdram_refresh, sdram_burst});
        end
        {core_sdram_rd, core_sdram_wr, core_sdram_refresh, core_sdram_burst} <= 4'd0;
        wait_cycles(10);

        run_restore(1'b0);
        wait_cycles(5);
        run_restore(1'b1);
        wait_cycles(5);
        run_backup();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
cdi_host_pkg.sv
host_reset_ctrl.sv
worm_byte_splitter.sv
sdram_prepare_arbiter.sv
nvram_transfer_fsm.sv
cdi_host_bridge.sv
tb_cdi_host_bridge.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_cdi_host_bridge -f verilog.f -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir
